/* Makefile */
SIM = obj_dir/llc_frontend_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module llc_frontend_tb \
		-f llc_frontend.f --Mdir obj_dir -o llc_frontend_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/input_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module input_decoder (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     rst_valid,
    input  wire                     rsp_valid,
    input  wire                     req_valid,
    input  wire                     dma_valid,
    input  wire llc_ctrl_pkg::status_t status,
    input  wire                     stalled_valid,
    input  wire                     decode_en,
    output logic                    update_from_stalled,
    output logic                    rst_ready,
    output logic                    rsp_ready,
    output logic                    req_ready,
    output logic                    dma_ready,
    output logic                    look,
    output llc_ctrl_pkg::action_e   action
);

    logic rst_q;
    logic rsp_q;
    logic req_q;
    logic dma_q;
    llc_ctrl_pkg::action_e act_next;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_q <= 1'b0;
            rsp_q <= 1'b0;
            req_q <= 1'b0;
            dma_q <= 1'b0;
        end else begin
            rst_q <= rst_valid;
            rsp_q <= rsp_valid;
            req_q <= req_valid;
            dma_q <= dma_valid;
        end
    end

    // Fixed priority, evaluated only in the decode cycle.
    always_comb begin
        act_next = llc_ctrl_pkg::NONE;
        if (decode_en) begin
            if (status.recall_pending) begin
                if (!status.recall_valid) begin
                    if (rsp_q) begin
                        act_next = llc_ctrl_pkg::RSP_GET;  // Waiting on the recalled line.
                    end
                end else if (status.dma_read_pending) begin
                    act_next = llc_ctrl_pkg::DMA_READ_RESUME;
                end else if (status.dma_write_pending) begin
                    act_next = llc_ctrl_pkg::DMA_WRITE_RESUME;
                end
            end else if (status.rst_stall) begin
                act_next = llc_ctrl_pkg::RST_RESUME;
            end else if (status.flush_stall) begin
                act_next = llc_ctrl_pkg::FLUSH_RESUME;
            end else if (rst_q && !status.dma_read_pending && !status.dma_write_pending) begin
                act_next = llc_ctrl_pkg::RST_GET;
            end else if (rsp_q) begin
                act_next = llc_ctrl_pkg::RSP_GET;
            end else if (!status.req_stall && (stalled_valid || req_q)) begin
                if (stalled_valid) begin
                    act_next = llc_ctrl_pkg::REQ_STALLED;  // Older request goes first.
                end else begin
                    act_next = llc_ctrl_pkg::REQ_GET;
                end
            end else if (status.dma_read_pending) begin
                act_next = llc_ctrl_pkg::DMA_READ_RESUME;
            end else if (status.dma_write_pending) begin
                if (dma_q) begin
                    act_next = llc_ctrl_pkg::DMA_WRITE_RESUME;
                end
            end else if (dma_q && !status.req_stall) begin
                act_next = llc_ctrl_pkg::DMA_GET;
            end
        end
    end

    // Falls back to NONE outside decode, so every ready is one cycle wide.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            action <= llc_ctrl_pkg::NONE;
        end else begin
            action <= act_next;
        end
    end

    assign rst_ready = (action == llc_ctrl_pkg::RST_GET);
    assign rsp_ready = (action == llc_ctrl_pkg::RSP_GET);
    assign req_ready = (action == llc_ctrl_pkg::REQ_GET);
    assign update_from_stalled = (action == llc_ctrl_pkg::REQ_STALLED);

    // A recall resume replays the word already held.
    assign dma_ready = (action == llc_ctrl_pkg::DMA_GET) ||
                       ((action == llc_ctrl_pkg::DMA_WRITE_RESUME) && !status.recall_pending);

    assign look = (action inside {llc_ctrl_pkg::RSP_GET, llc_ctrl_pkg::REQ_GET,
                                  llc_ctrl_pkg::REQ_STALLED, llc_ctrl_pkg::DMA_GET}) ||
                  ((action inside {llc_ctrl_pkg::DMA_READ_RESUME,
                                   llc_ctrl_pkg::DMA_WRITE_RESUME}) && !status.recall_pending);

endmodule

`default_nettype wire

/* design/input_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module input_regs (
    input  wire                         clk,
    input  wire                         rst,
    input  wire llc_msg_pkg::rst_msg_t  rst_msg,
    input  wire llc_msg_pkg::rsp_msg_t  rsp_msg,
    input  wire llc_msg_pkg::req_msg_t  req_msg,
    input  wire llc_msg_pkg::dma_msg_t  dma_msg,
    input  wire                         rst_ready,
    input  wire                         rsp_ready,
    input  wire                         req_ready,
    input  wire                         dma_ready,
    input  wire                         stall_load,
    input  wire                         update_from_stalled,
    output llc_msg_pkg::rst_msg_t       cur_rst,
    output llc_msg_pkg::rsp_msg_t       cur_rsp,
    output llc_msg_pkg::req_msg_t       cur_req,
    output llc_msg_pkg::dma_msg_t       cur_dma,
    output logic                        stalled_valid
);

    llc_msg_pkg::req_msg_t stalled_req;

    always_ff @(posedge clk) begin
        if (rst_ready) begin
            cur_rst <= rst_msg;
        end
        if (rsp_ready) begin
            cur_rsp <= rsp_msg;
        end
        if (req_ready) begin
            cur_req <= req_msg;
        end else if (update_from_stalled) begin
            cur_req <= stalled_req;  // Replay the parked request.
        end
        if (dma_ready) begin
            cur_dma <= dma_msg;
        end
        if (stall_load) begin
            stalled_req <= cur_req;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stalled_valid <= 1'b0;
        end else if (stall_load) begin
            stalled_valid <= 1'b1;
        end else if (update_from_stalled) begin
            stalled_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/llc_ctrl_pkg.sv */
`default_nettype none

package llc_ctrl_pkg;

    typedef enum logic [3:0] {
        NONE             = 4'd0,
        RST_GET          = 4'd1,
        RST_RESUME       = 4'd2,
        FLUSH_RESUME     = 4'd3,
        RSP_GET          = 4'd4,
        REQ_GET          = 4'd5,
        REQ_STALLED      = 4'd6,
        DMA_GET          = 4'd7,
        DMA_READ_RESUME  = 4'd8,
        DMA_WRITE_RESUME = 4'd9
    } action_e;

    typedef enum logic [1:0] {
        DECODE = 2'd0,
        ACT    = 2'd1,
        EXEC   = 2'd2
    } round_e;

    typedef enum logic [3:0] {
        WALK_RST    = 4'd0,
        WALK_FLUSH  = 4'd1,
        RSP_DONE    = 4'd2,
        REQ_HIT     = 4'd3,
        REQ_MISS    = 4'd4,
        REQ_STALL   = 4'd5,
        DMA_BEAT_RD = 4'd6,
        DMA_BEAT_WR = 4'd7,
        RECALL      = 4'd8
    } evt_kind_e;

    typedef struct packed {
        evt_kind_e          kind;
        llc_msg_pkg::addr_t addr;
        llc_msg_pkg::beat_t beat;  // Zero for non-DMA events.
    } llc_evt_t;

    typedef struct packed {
        logic recall_pending;
        logic recall_valid;
        logic dma_read_pending;
        logic dma_write_pending;
        logic flush_stall;
        logic rst_stall;
        logic req_stall;
    } status_t;

endpackage

`default_nettype wire

/* design/llc_frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_frontend_top #(
    parameter int NUM_SETS = 16
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rst_valid,
    input  wire llc_msg_pkg::rst_msg_t  rst_msg,
    input  wire                         rsp_valid,
    input  wire llc_msg_pkg::rsp_msg_t  rsp_msg,
    input  wire                         req_valid,
    input  wire llc_msg_pkg::req_msg_t  req_msg,
    input  wire                         dma_valid,
    input  wire llc_msg_pkg::dma_msg_t  dma_msg,
    output logic                        rst_ready,
    output logic                        rsp_ready,
    output logic                        req_ready,
    output logic                        dma_ready,
    output logic                        evt_valid,
    output llc_ctrl_pkg::llc_evt_t      evt,
    output logic                        mem_rd_valid,
    output llc_msg_pkg::addr_t          mem_rd_addr
);

    llc_ctrl_pkg::status_t status;
    llc_ctrl_pkg::action_e action;
    llc_msg_pkg::rst_msg_t cur_rst;
    llc_msg_pkg::rsp_msg_t cur_rsp;
    llc_msg_pkg::req_msg_t cur_req;
    llc_msg_pkg::dma_msg_t cur_dma;
    logic                  decode_en;
    logic                  look;
    logic                  stalled_valid;
    logic                  stall_load;
    logic                  update_from_stalled;

    input_decoder input_decoder_i (
        .clk                 (clk),
        .rst                 (rst),
        .rst_valid           (rst_valid),
        .rsp_valid           (rsp_valid),
        .req_valid           (req_valid),
        .dma_valid           (dma_valid),
        .status              (status),
        .stalled_valid       (stalled_valid),
        .decode_en           (decode_en),
        .update_from_stalled (update_from_stalled),
        .rst_ready           (rst_ready),
        .rsp_ready           (rsp_ready),
        .req_ready           (req_ready),
        .dma_ready           (dma_ready),
        .look                (look),
        .action              (action)
    );

    input_regs input_regs_i (
        .clk                 (clk),
        .rst                 (rst),
        .rst_msg             (rst_msg),
        .rsp_msg             (rsp_msg),
        .req_msg             (req_msg),
        .dma_msg             (dma_msg),
        .rst_ready           (rst_ready),
        .rsp_ready           (rsp_ready),
        .req_ready           (req_ready),
        .dma_ready           (dma_ready),
        .stall_load          (stall_load),
        .update_from_stalled (update_from_stalled),
        .cur_rst             (cur_rst),
        .cur_rsp             (cur_rsp),
        .cur_req             (cur_req),
        .cur_dma             (cur_dma),
        .stalled_valid       (stalled_valid)
    );

    llc_round_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) llc_round_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .action        (action),
        .look          (look),
        .cur_rst       (cur_rst),
        .cur_rsp       (cur_rsp),
        .cur_req       (cur_req),
        .cur_dma       (cur_dma),
        .stalled_valid (stalled_valid),
        .decode_en     (decode_en),
        .status        (status),
        .stall_load    (stall_load),
        .evt_valid     (evt_valid),
        .evt           (evt),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_addr   (mem_rd_addr)
    );

endmodule

`default_nettype wire

/* design/llc_msg_pkg.sv */
`default_nettype none

package llc_msg_pkg;

    localparam int ADDR_BITS = 16;  // Line address.
    localparam int SET_BITS  = 4;   // Set index, low bits of the address.
    localparam int BEAT_BITS = 3;   // DMA length field.

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [SET_BITS-1:0]  set_t;
    typedef logic [BEAT_BITS-1:0] beat_t;

    typedef enum logic [1:0] {
        GETS = 2'd0,
        GETM = 2'd1,
        PUTM = 2'd2
    } coh_op_e;

    typedef enum logic {
        DMA_READ  = 1'b0,
        DMA_WRITE = 1'b1
    } dma_op_e;

    typedef struct packed {
        logic flush;  // 0 runs a reset walk, 1 a flush walk.
    } rst_msg_t;

    typedef struct packed {
        coh_op_e op;
        addr_t   addr;
    } req_msg_t;

    typedef struct packed {
        addr_t addr;
    } rsp_msg_t;

    typedef struct packed {
        dma_op_e op;
        addr_t   addr;
        beat_t   beats;  // Beats minus one.
    } dma_msg_t;

endpackage

`default_nettype wire

/* design/llc_round_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_round_ctrl #(
    parameter int NUM_SETS = 16
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire llc_ctrl_pkg::action_e  action,
    input  wire                         look,
    input  wire llc_msg_pkg::rst_msg_t  cur_rst,
    input  wire llc_msg_pkg::rsp_msg_t  cur_rsp,
    input  wire llc_msg_pkg::req_msg_t  cur_req,
    input  wire llc_msg_pkg::dma_msg_t  cur_dma,
    input  wire                         stalled_valid,
    output logic                        decode_en,
    output llc_ctrl_pkg::status_t       status,
    output logic                        stall_load,
    output logic                        evt_valid,
    output llc_ctrl_pkg::llc_evt_t      evt,
    output logic                        mem_rd_valid,
    output llc_msg_pkg::addr_t          mem_rd_addr
);

    localparam llc_msg_pkg::set_t LAST_SET = llc_msg_pkg::set_t'(NUM_SETS - 1);

    llc_ctrl_pkg::round_e  state;
    llc_ctrl_pkg::action_e act_q;
    llc_ctrl_pkg::status_t st;
    logic                  look_q;
    logic [NUM_SETS-1:0]   busy;
    llc_msg_pkg::set_t     walk_cnt;
    llc_msg_pkg::set_t     walk_idx;
    llc_msg_pkg::set_t     stall_set;
    llc_msg_pkg::set_t     recall_set;
    llc_msg_pkg::set_t     req_set;
    llc_msg_pkg::set_t     rsp_set;
    llc_msg_pkg::set_t     dma_set;
    llc_msg_pkg::addr_t    dma_base;
    llc_msg_pkg::addr_t    dma_base_x;
    llc_msg_pkg::addr_t    dma_addr_x;
    llc_msg_pkg::beat_t    dma_beat;
    llc_msg_pkg::beat_t    dma_cnt;
    llc_msg_pkg::beat_t    dma_idx_x;
    llc_msg_pkg::beat_t    dma_cnt_x;
    logic                  walk_flush;
    logic                  walk_last;
    logic                  dma_wr_x;
    logic                  dma_last;
    logic                  dma_new;
    logic                  req_busy;
    logic                  dma_busy;

    assign decode_en = (state == llc_ctrl_pkg::DECODE);
    assign status = st;
    assign mem_rd_addr = cur_req.addr;

    // A walk starts at set 0 on the command itself.
    assign walk_flush = (act_q == llc_ctrl_pkg::RST_GET) ? cur_rst.flush : st.flush_stall;
    assign walk_idx = (act_q == llc_ctrl_pkg::RST_GET) ? '0 : walk_cnt;
    assign walk_last = (walk_idx == LAST_SET);

    assign dma_new = (act_q == llc_ctrl_pkg::DMA_GET);
    assign dma_base_x = dma_new ? cur_dma.addr : dma_base;
    assign dma_idx_x = dma_new ? '0 : dma_beat;
    assign dma_cnt_x = dma_new ? cur_dma.beats : dma_cnt;
    assign dma_wr_x = dma_new ? (cur_dma.op == llc_msg_pkg::DMA_WRITE) : st.dma_write_pending;
    assign dma_addr_x = dma_base_x + llc_msg_pkg::addr_t'(dma_idx_x);
    assign dma_last = (dma_idx_x == dma_cnt_x);

    assign req_set = cur_req.addr[llc_msg_pkg::SET_BITS-1:0];
    assign rsp_set = cur_rsp.addr[llc_msg_pkg::SET_BITS-1:0];
    assign dma_set = dma_addr_x[llc_msg_pkg::SET_BITS-1:0];
    assign req_busy = look_q && busy[req_set];
    assign dma_busy = look_q && busy[dma_set];

    always_comb begin
        evt_valid = 1'b0;
        evt = '0;
        mem_rd_valid = 1'b0;
        stall_load = 1'b0;
        if (state == llc_ctrl_pkg::EXEC) begin
            case (act_q)
                llc_ctrl_pkg::RST_GET, llc_ctrl_pkg::RST_RESUME, llc_ctrl_pkg::FLUSH_RESUME: begin
                    evt_valid = 1'b1;
                    evt.kind = walk_flush ? llc_ctrl_pkg::WALK_FLUSH : llc_ctrl_pkg::WALK_RST;
                    evt.addr = llc_msg_pkg::addr_t'(walk_idx);
                end
                llc_ctrl_pkg::RSP_GET: begin
                    evt_valid = 1'b1;
                    evt.kind = llc_ctrl_pkg::RSP_DONE;
                    evt.addr = cur_rsp.addr;
                end
                llc_ctrl_pkg::REQ_GET, llc_ctrl_pkg::REQ_STALLED: begin
                    evt_valid = 1'b1;
                    evt.addr = cur_req.addr;
                    if (req_busy) begin
                        stall_load = 1'b1;
                        evt.kind = llc_ctrl_pkg::REQ_STALL;
                    end else if (cur_req.op == llc_msg_pkg::PUTM) begin
                        evt.kind = llc_ctrl_pkg::REQ_HIT;
                    end else begin
                        evt.kind = llc_ctrl_pkg::REQ_MISS;
                        mem_rd_valid = 1'b1;
                    end
                end
                llc_ctrl_pkg::DMA_GET, llc_ctrl_pkg::DMA_READ_RESUME,
                llc_ctrl_pkg::DMA_WRITE_RESUME: begin
                    evt_valid = 1'b1;
                    evt.addr = dma_addr_x;
                    if (dma_busy) begin
                        evt.kind = llc_ctrl_pkg::RECALL;
                    end else begin
                        evt.kind = dma_wr_x ? llc_ctrl_pkg::DMA_BEAT_WR : llc_ctrl_pkg::DMA_BEAT_RD;
                        evt.beat = dma_idx_x;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= llc_ctrl_pkg::EXEC;  // First round opens after release.
            act_q <= llc_ctrl_pkg::NONE;
            look_q <= 1'b0;
            st <= '0;
            busy <= '0;
            walk_cnt <= '0;
            dma_beat <= '0;
        end else begin
            case (state)
                llc_ctrl_pkg::DECODE: state <= llc_ctrl_pkg::ACT;
                llc_ctrl_pkg::ACT: state <= llc_ctrl_pkg::EXEC;
                default: state <= llc_ctrl_pkg::DECODE;
            endcase
            if (state == llc_ctrl_pkg::ACT) begin
                act_q <= action;
                look_q <= look;
            end
            if (state == llc_ctrl_pkg::EXEC) begin
                case (act_q)
                    llc_ctrl_pkg::RST_GET, llc_ctrl_pkg::RST_RESUME,
                    llc_ctrl_pkg::FLUSH_RESUME: begin
                        busy[walk_idx] <= 1'b0;
                        walk_cnt <= walk_idx + 1'b1;
                        st.rst_stall <= !walk_last && !walk_flush;
                        st.flush_stall <= !walk_last && walk_flush;
                    end
                    llc_ctrl_pkg::RSP_GET: begin
                        busy[rsp_set] <= 1'b0;
                        if (st.req_stall && stalled_valid && (stall_set == rsp_set)) begin
                            st.req_stall <= 1'b0;
                        end
                        if (st.recall_pending && (recall_set == rsp_set)) begin
                            st.recall_valid <= 1'b1;
                        end
                    end
                    llc_ctrl_pkg::REQ_GET, llc_ctrl_pkg::REQ_STALLED: begin
                        if (req_busy) begin
                            st.req_stall <= 1'b1;
                        end else if (cur_req.op != llc_msg_pkg::PUTM) begin
                            busy[req_set] <= 1'b1;  // Line is being filled.
                        end
                    end
                    llc_ctrl_pkg::DMA_GET, llc_ctrl_pkg::DMA_READ_RESUME,
                    llc_ctrl_pkg::DMA_WRITE_RESUME: begin
                        st.recall_pending <= dma_busy;
                        st.recall_valid <= 1'b0;
                        st.dma_read_pending <= (dma_busy || !dma_last) && !dma_wr_x;
                        st.dma_write_pending <= (dma_busy || !dma_last) && dma_wr_x;
                        dma_beat <= dma_busy ? dma_idx_x : dma_idx_x + 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == llc_ctrl_pkg::EXEC) begin
            if (dma_new) begin
                dma_base <= cur_dma.addr;
                dma_cnt <= cur_dma.beats;
            end
            if (stall_load) begin
                stall_set <= req_set;
            end
            if (evt.kind == llc_ctrl_pkg::RECALL && evt_valid) begin
                recall_set <= dma_set;
            end
        end
    end

endmodule

`default_nettype wire

/* llc_frontend.f */
design/llc_msg_pkg.sv
design/llc_ctrl_pkg.sv
design/input_decoder.sv
design/input_regs.sv
design/llc_round_ctrl.sv
design/llc_frontend_top.sv
sim/llc_frontend_tb.sv

/* sim/llc_frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_frontend_tb;

    localparam int NUM_SETS = 16;
    localparam int ITEMS = 113;
    localparam int LIMIT = ITEMS * 40 * 3 + 4 * NUM_SETS * 3;

    logic clk;
    logic rst;
    logic rst_valid, rsp_valid, req_valid, dma_valid;
    llc_msg_pkg::rst_msg_t rst_msg;
    llc_msg_pkg::rsp_msg_t rsp_msg;
    llc_msg_pkg::req_msg_t req_msg;
    llc_msg_pkg::dma_msg_t dma_msg;
    logic rst_ready, rsp_ready, req_ready, dma_ready;
    logic evt_valid, mem_rd_valid;
    llc_ctrl_pkg::llc_evt_t evt;
    llc_msg_pkg::addr_t mem_rd_addr;

    integer seed = 32'hef53_d3cd;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int rst_left = 0, rsp_left = 0, req_left = 0, dma_left = 0;
    int walk_rst_n = 0, walk_fl_n = 0;
    logic flush_next = 1'b0, flush_rand = 1'b0;
    logic acc_rst = 0, acc_rsp = 0, acc_req = 0, acc_dma = 0;
    logic [3:0] h1 = '0, h2 = '0;  // Valids as rst, rsp, req, dma.

    // Reference model state.
    logic [NUM_SETS-1:0] busy_m = '0;
    logic walk_on = 0, walk_fl = 0;
    int walk_idx = 0;
    logic stl_on = 0, stl_flag = 0;
    llc_msg_pkg::req_msg_t stl_req, req_acc;
    llc_msg_pkg::rsp_msg_t rsp_acc;
    logic dma_on = 0, dma_wr = 0, rc_pend = 0, rc_valid = 0;
    llc_msg_pkg::addr_t dma_base;
    llc_msg_pkg::beat_t dma_cnt, dma_idx;
    llc_msg_pkg::set_t rc_set;
    int src = 0;  // 1 rst, 2 rsp, 3 req, 4 dma.

    llc_frontend_top #(.NUM_SETS(NUM_SETS)) llc_frontend_top_i (
        .clk(clk), .rst(rst),
        .rst_valid(rst_valid), .rst_msg(rst_msg), .rsp_valid(rsp_valid), .rsp_msg(rsp_msg),
        .req_valid(req_valid), .req_msg(req_msg), .dma_valid(dma_valid), .dma_msg(dma_msg),
        .rst_ready(rst_ready), .rsp_ready(rsp_ready), .req_ready(req_ready),
        .dma_ready(dma_ready), .evt_valid(evt_valid), .evt(evt),
        .mem_rd_valid(mem_rd_valid), .mem_rd_addr(mem_rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_evt(input llc_ctrl_pkg::llc_evt_t got, input llc_ctrl_pkg::llc_evt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: evt got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_addr(input llc_msg_pkg::addr_t got, input llc_msg_pkg::addr_t exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report(input string msg);
        errors++;
        $display("At %0t: %s", $time, msg);
    endtask

    function automatic llc_msg_pkg::addr_t pick_addr(input logic [31:0] r, input logic aim,
                                                      input llc_msg_pkg::set_t set);
        if (aim) begin
            return {r[15:4], set};
        end
        return {r[15:4], 2'b00, r[1:0]};  // Sets 0 to 3 only, so lines collide.
    endfunction

    task automatic walk_step();
        llc_ctrl_pkg::llc_evt_t e;
        e = '0;
        e.kind = walk_fl ? llc_ctrl_pkg::WALK_FLUSH : llc_ctrl_pkg::WALK_RST;
        e.addr = llc_msg_pkg::addr_t'(walk_idx);
        check_evt(evt, e);
        check_flag(mem_rd_valid, 1'b0, "mem_rd_valid");
        busy_m[walk_idx] = 1'b0;
        if (walk_fl) walk_fl_n++;
        else walk_rst_n++;
        walk_idx++;
        if (walk_idx == NUM_SETS) walk_on = 1'b0;
    endtask

    task automatic rsp_step();
        llc_ctrl_pkg::llc_evt_t e;
        llc_msg_pkg::set_t s;
        s = rsp_acc.addr[3:0];
        e = '0;
        e.kind = llc_ctrl_pkg::RSP_DONE;
        e.addr = rsp_acc.addr;
        check_evt(evt, e);
        check_flag(mem_rd_valid, 1'b0, "mem_rd_valid");
        busy_m[s] = 1'b0;
        if (stl_on && stl_flag && stl_req.addr[3:0] == s) stl_flag = 1'b0;
        if (rc_pend && rc_set == s) rc_valid = 1'b1;
    endtask

    task automatic req_step(input llc_msg_pkg::req_msg_t m);
        llc_ctrl_pkg::llc_evt_t e;
        e = '0;
        e.addr = m.addr;
        stl_on = 1'b0;
        if (busy_m[m.addr[3:0]]) begin
            e.kind = llc_ctrl_pkg::REQ_STALL;
            stl_on = 1'b1;
            stl_flag = 1'b1;
            stl_req = m;
        end else if (m.op == llc_msg_pkg::PUTM) begin
            e.kind = llc_ctrl_pkg::REQ_HIT;
        end else begin
            e.kind = llc_ctrl_pkg::REQ_MISS;
            busy_m[m.addr[3:0]] = 1'b1;
            check_addr(mem_rd_addr, m.addr, "mem_rd_addr");
        end
        check_flag(mem_rd_valid, e.kind == llc_ctrl_pkg::REQ_MISS, "mem_rd_valid");
        check_evt(evt, e);
    endtask

    task automatic dma_step(input logic look);
        llc_ctrl_pkg::llc_evt_t e;
        llc_msg_pkg::addr_t a;
        a = dma_base + llc_msg_pkg::addr_t'(dma_idx);
        e = '0;
        e.addr = a;
        rc_valid = 1'b0;
        if (look && busy_m[a[3:0]]) begin
            e.kind = llc_ctrl_pkg::RECALL;
            rc_pend = 1'b1;
            rc_set = a[3:0];
        end else begin
            e.kind = dma_wr ? llc_ctrl_pkg::DMA_BEAT_WR : llc_ctrl_pkg::DMA_BEAT_RD;
            e.beat = dma_idx;
            rc_pend = 1'b0;
            if (dma_idx == dma_cnt) dma_on = 1'b0;
            else dma_idx = dma_idx + 3'd1;
        end
        check_evt(evt, e);
        check_flag(mem_rd_valid, 1'b0, "mem_rd_valid");
    endtask

    always @(posedge clk) begin
        h2 <= h1;
        h1 <= {rst_valid, rsp_valid, req_valid, dma_valid};
    end

    // Sampled mid-cycle, where every DUT output is settled.
    always @(negedge clk) begin
        if (rst) begin
            if (int'(rst_ready) + int'(rsp_ready) + int'(req_ready) + int'(dma_ready) > 1)
                report("more than one ready in a cycle");
            if (walk_on && (rst_ready || rsp_ready || req_ready || dma_ready))
                report("ready seen during a walk");
            if (src != 0 && (rst_ready || rsp_ready || req_ready || dma_ready))
                report("ready seen before the previous action finished");
            if ((rst_ready && !rst_valid) || (rsp_ready && !rsp_valid) ||
                (req_ready && !req_valid) || (dma_ready && !dma_valid))
                report("ready seen on a channel without valid");
            if ((rsp_ready || req_ready || dma_ready) && h2[3] && !dma_on && !walk_on)
                report("reset command lost priority");
            if ((req_ready || dma_ready) && h2[2]) report("response lost priority");
            if (dma_ready && (h2[1] || stl_on) && !(stl_on && stl_flag))
                report("request lost priority to DMA");
            if ((req_ready || (dma_ready && !dma_on)) && stl_on)
                report("new item taken while a request is stalled");
            if (rst_ready && dma_on) report("reset command taken during DMA");
            if (rst_ready) begin
                src = 1;
                acc_rst = 1'b1;
                walk_on = 1'b1;
                walk_idx = 0;
                walk_fl = rst_msg.flush;
            end
            if (rsp_ready) begin
                src = 2;
                acc_rsp = 1'b1;
                rsp_acc = rsp_msg;
            end
            if (req_ready) begin
                src = 3;
                acc_req = 1'b1;
                req_acc = req_msg;
            end
            if (dma_ready) begin
                src = 4;
                acc_dma = 1'b1;
                if (!dma_on) begin
                    dma_on = 1'b1;
                    dma_base = dma_msg.addr;
                    dma_cnt = dma_msg.beats;
                    dma_idx = '0;
                    dma_wr = (dma_msg.op == llc_msg_pkg::DMA_WRITE);
                end
            end
            if (evt_valid) begin
                case (src)
                    1: walk_step();
                    2: rsp_step();
                    3: req_step(req_acc);
                    4: dma_step(1'b1);
                    default: begin
                        if (rc_pend && rc_valid) dma_step(1'b0);
                        else if (walk_on) walk_step();
                        else if (stl_on && !stl_flag) req_step(stl_req);
                        else if (dma_on && !dma_wr && !rc_pend) dma_step(1'b1);
                        else report("event with no action behind it");
                    end
                endcase
                src = 0;
            end else if (mem_rd_valid) begin
                report("mem_rd strobe without a request");
            end
        end
    end

    // Channel sources, driven shortly after each rising edge.
    always @(posedge clk) begin
        logic [31:0] r;
        logic need;
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout after %0d cycles with events still outstanding", cycles);
            $display("Test failures found");
            $finish;
        end else begin
            #2;
            if (acc_rst) rst_valid = 1'b0;
            if (acc_rsp) rsp_valid = 1'b0;
            if (acc_req) req_valid = 1'b0;
            if (acc_dma) dma_valid = 1'b0;
            {acc_rst, acc_rsp, acc_req, acc_dma} = '0;
            r = $random(seed);
            if (!rst_valid && rst_left > 0 && r[21:20] == 2'd0) begin
                rst_valid = 1'b1;
                rst_msg.flush = flush_rand ? r[5] : flush_next;
                rst_left--;
            end
            need = (stl_on && stl_flag) || (rc_pend && !rc_valid);
            if (!rsp_valid && (rsp_left > 0 || need) && r[23:22] == 2'd0) begin
                rsp_valid = 1'b1;
                rsp_msg.addr = pick_addr(r, need, rc_pend ? rc_set : stl_req.addr[3:0]);
                if (rsp_left > 0) rsp_left--;
            end
            r = $random(seed);
            if (!req_valid && req_left > 0 && r[25:24] == 2'd0) begin
                req_valid = 1'b1;
                req_msg.addr = pick_addr(r, 1'b0, '0);
                req_msg.op = (r[17:16] == 2'd0) ? llc_msg_pkg::GETS :
                             (r[17:16] == 2'd1) ? llc_msg_pkg::GETM : llc_msg_pkg::PUTM;
                req_left--;
            end
            r = $random(seed);
            if (!dma_valid && (dma_left > 0 || (dma_on && dma_wr)) && r[27:26] == 2'd0) begin
                dma_valid = 1'b1;
                dma_msg.addr = pick_addr(r, 1'b0, '0);
                dma_msg.op = r[8] ? llc_msg_pkg::DMA_WRITE : llc_msg_pkg::DMA_READ;
                dma_msg.beats = r[11:9];
                if (dma_left > 0) dma_left--;
            end
        end
    end

    task automatic run_test(input int n, input string name, input int nr, input int np,
                            input int nq, input int nd);
        int err_start;
        err_start = errors;
        rst_left = nr;
        rsp_left = np;
        req_left = nq;
        dma_left = nd;
        do @(posedge clk);
        while (rst_left + rsp_left + req_left + dma_left > 0 || rst_valid || rsp_valid ||
               req_valid || dma_valid || src != 0 || walk_on || dma_on || stl_on);
        repeat (6) @(posedge clk);
        $display("test %0d %s: finished with %0d errors", n, name, errors - err_start);
    endtask

    initial begin
        rst = 1'b0;
        {rst_valid, rsp_valid, req_valid, dma_valid} = '0;
        rst_msg = '0;
        rsp_msg = '0;
        req_msg = '0;
        dma_msg = '0;
        repeat (16) @(posedge clk);
        #2 rst = 1'b1;
        run_test(1, "reset walk", 1, 0, 0, 0);
        flush_next = 1'b1;
        run_test(1, "flush walk", 1, 0, 0, 0);
        if (walk_rst_n != NUM_SETS || walk_fl_n != NUM_SETS)
            report("walk did not cover every set once");
        run_test(2, "requests and responses", 0, 15, 30, 0);
        run_test(3, "dma with recalls", 0, 6, 6, 12);
        flush_rand = 1'b1;
        run_test(4, "all channels mixed", 2, 12, 20, 8);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
